//--- hw/fcore_pkg.sv
package fcore_pkg;

    // Data path and instruction word widths
    localparam int DATA_WIDTH = 32;
    localparam int INSTR_WIDTH = 32;
    localparam int OPCODE_WIDTH = 4;
    localparam int REG_ADDR_WIDTH = 4;
    localparam int IMM_WIDTH = 16;

    // Storage sizes, the address widths follow from them
    localparam int PROGRAM_DEPTH = 64;
    localparam int REG_COUNT = 16;
    localparam int PROG_ADDR_WIDTH = $clog2(PROGRAM_DEPTH);

    // Lowest bit of each field inside an instruction word
    localparam int OPCODE_LSB = 28;
    localparam int DEST_LSB = 24;
    localparam int SRC_A_LSB = 20;
    localparam int SRC_B_LSB = 16;
    localparam int IMM_LSB = 0;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [INSTR_WIDTH-1:0] instruction_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [PROG_ADDR_WIDTH-1:0] program_addr_t;
    typedef logic [IMM_WIDTH-1:0] immediate_t;

    // Compares only touch the condition flag, csel reads it
    typedef enum logic [OPCODE_WIDTH-1:0] {
        op_nop  = 4'h0,
        op_ldi  = 4'h1,
        op_add  = 4'h2,
        op_sub  = 4'h3,
        op_bgt  = 4'h4,
        op_ble  = 4'h5,
        op_beq  = 4'h6,
        op_csel = 4'h7,
        op_stop = 4'h8
    } opcode_e;

    // One instruction walks fetch, issue and write before the next fetch
    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_issue,
        st_write
    } ctrl_state_e;

    // Field extraction from a raw instruction word
    function automatic opcode_e instr_opcode(instruction_t word);
        return opcode_e'(word[OPCODE_LSB +: OPCODE_WIDTH]);
    endfunction

    function automatic reg_addr_t instr_dest(instruction_t word);
        return word[DEST_LSB +: REG_ADDR_WIDTH];
    endfunction

    function automatic reg_addr_t instr_src_a(instruction_t word);
        return word[SRC_A_LSB +: REG_ADDR_WIDTH];
    endfunction

    function automatic reg_addr_t instr_src_b(instruction_t word);
        return word[SRC_B_LSB +: REG_ADDR_WIDTH];
    endfunction

    function automatic immediate_t instr_imm(instruction_t word);
        return word[IMM_LSB +: IMM_WIDTH];
    endfunction

    // True for the opcodes that end with a register file write
    function automatic logic writes_register(opcode_e op);
        return (op == op_ldi) || (op == op_add) || (op == op_sub) || (op == op_csel);
    endfunction

endpackage

//--- hw/exec_if.sv
`timescale 1ns/1ps

interface exec_if import fcore_pkg::*; ();

    // Issue side, valid is a single cycle strobe per instruction
    logic    valid;
    opcode_e op;
    reg_addr_t dest;
    data_t   operand_a;
    data_t   operand_b;

    // Writeback side, registered in the executor
    data_t     result;
    logic      write_en;
    reg_addr_t write_dest;

    // The control unit issues and watches the writeback slot
    modport control (
        output valid, op, dest, operand_a, operand_b,
        input  result, write_en, write_dest
    );

    // There is no back-pressure so the executor takes every issue
    modport executor (
        input  valid, op, dest, operand_a, operand_b,
        output result, write_en, write_dest
    );

endinterface

//--- hw/fcore_program_memory.sv
`timescale 1ns/1ps

module fcore_program_memory import fcore_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          prog_we,
    input  program_addr_t prog_addr,
    input  instruction_t  prog_data,
    input  program_addr_t fetch_addr,
    output instruction_t  fetch_data
);

    // Instruction store, one word per program address
    instruction_t mem [PROGRAM_DEPTH];

    // Host writes land at the clock edge
    // A reset empties the whole program so every word reads as nop
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PROGRAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Fetch port with one cycle of latency
    // A write and a fetch to the same word return the old contents
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fetch_data <= '0;
        end else begin
            fetch_data <= mem[fetch_addr];
        end
    end

endmodule

//--- hw/fcore_register_file.sv
`timescale 1ns/1ps

module fcore_register_file import fcore_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  reg_addr_t rd_a_addr,
    output data_t     rd_a_data,
    input  reg_addr_t rd_b_addr,
    output data_t     rd_b_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  data_t     wr_data,
    input  reg_addr_t host_addr,
    output data_t     host_data
);

    // General purpose registers, r0 is an ordinary register here
    data_t regs [REG_COUNT];

    // Single write port driven by the executor
    // Every register starts from zero after reset
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Operand reads are combinational so the issue cycle sees them directly
    assign rd_a_data = regs[rd_a_addr];
    assign rd_b_data = regs[rd_b_addr];

    // Host readback is registered
    // The value appears one cycle after host_addr is presented
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            host_data <= '0;
        end else begin
            host_data <= regs[host_addr];
        end
    end

endmodule

//--- hw/fcore_control_unit.sv
`timescale 1ns/1ps

module fcore_control_unit import fcore_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          run,
    output logic          done,
    output logic          busy,
    output program_addr_t fetch_addr,
    input  instruction_t  fetch_data,
    output reg_addr_t     rd_a_addr,
    input  data_t         rd_a_data,
    output reg_addr_t     rd_b_addr,
    input  data_t         rd_b_data,
    exec_if.control       exec
);

    ctrl_state_e   state;
    program_addr_t pc;
    opcode_e       opcode;
    reg_addr_t     src_a;
    reg_addr_t     src_b;
    data_t         value_a;
    data_t         value_b;

    // Decode the word that the memory returned for the current pc
    assign opcode = instr_opcode(fetch_data);
    assign src_a = instr_src_a(fetch_data);
    assign src_b = instr_src_b(fetch_data);

    // The pc only moves at the end of issue, so fetch_data stays put through issue
    assign fetch_addr = pc;
    assign rd_a_addr = src_a;
    assign rd_b_addr = src_b;

    // Anything other than idle counts as running a program
    assign busy = (state != st_idle);

    // Take a result from the executor when it still sits in the writeback slot
    // With fetch after write this never matches, it guards any overlap of the two
    always_comb begin
        value_a = rd_a_data;
        value_b = rd_b_data;
        if (exec.write_en && (exec.write_dest == src_a)) begin
            value_a = exec.result;
        end
        if (exec.write_en && (exec.write_dest == src_b)) begin
            value_b = exec.result;
        end
    end

    // Issue strobe, a stop goes to done instead of to the executor
    assign exec.valid = (state == st_issue) && (opcode != op_stop);
    assign exec.op = opcode;
    assign exec.dest = instr_dest(fetch_data);

    // ldi carries its zero-extended immediate in the first operand slot
    assign exec.operand_a = (opcode == op_ldi) ? data_t'(instr_imm(fetch_data)) : value_a;
    assign exec.operand_b = value_b;

    // Sequencer
    // run is only looked at in idle, so a pulse while busy is dropped
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            pc <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (run) begin
                        pc <= '0;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    // Memory registers mem[pc] at this edge
                    state <= st_issue;
                end
                st_issue: begin
                    if (opcode == op_stop) begin
                        // done shows in the first idle cycle and lasts one cycle
                        done <= 1'b1;
                        state <= st_idle;
                    end else begin
                        // Past the last word the counter wraps to address 0
                        pc <= pc + 1'b1;
                        state <= st_write;
                    end
                end
                st_write: begin
                    // The register file takes the executor result at this edge
                    state <= st_fetch;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- hw/fcore_executor.sv
`timescale 1ns/1ps

module fcore_executor import fcore_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    exec_if.executor  exec,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output data_t     wr_data
);

    // Condition flag written by compares and read by csel
    logic      flag;
    logic      write_en_q;
    reg_addr_t write_dest_q;
    data_t     result_q;
    data_t     alu_out;
    logic      cmp_out;

    // Arithmetic and select path, two's complement wraps modulo 2^32
    always_comb begin
        case (exec.op)
            op_ldi:  alu_out = exec.operand_a;
            op_add:  alu_out = exec.operand_a + exec.operand_b;
            op_sub:  alu_out = exec.operand_a - exec.operand_b;
            op_csel: alu_out = flag ? exec.operand_a : exec.operand_b;
            default: alu_out = result_q;
        endcase
    end

    // Compares are signed, the flag keeps its value for anything else
    always_comb begin
        case (exec.op)
            op_bgt:  cmp_out = $signed(exec.operand_a) > $signed(exec.operand_b);
            op_ble:  cmp_out = $signed(exec.operand_a) <= $signed(exec.operand_b);
            op_beq:  cmp_out = exec.operand_a == exec.operand_b;
            default: cmp_out = flag;
        endcase
    end

    // Write strobe lasts exactly the cycle after issue
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_en_q <= 1'b0;
            flag <= 1'b0;
        end else begin
            write_en_q <= exec.valid && writes_register(exec.op);
            if (exec.valid) begin
                flag <= cmp_out;
            end
        end
    end

    // Result and destination only mean something while the strobe is high
    always_ff @(posedge clock) begin
        if (exec.valid) begin
            result_q <= alu_out;
            write_dest_q <= exec.dest;
        end
    end

    // Same writeback goes back to the control unit and out to the register file
    assign exec.result = result_q;
    assign exec.write_en = write_en_q;
    assign exec.write_dest = write_dest_q;
    assign wr_en = write_en_q;
    assign wr_addr = write_dest_q;
    assign wr_data = result_q;

endmodule

//--- hw/fcore.sv
`timescale 1ns/1ps

module fcore import fcore_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          run,
    output logic          done,
    output logic          busy,
    input  logic          prog_we,
    input  program_addr_t prog_addr,
    input  instruction_t  prog_data,
    input  reg_addr_t     reg_rd_addr,
    output data_t         reg_rd_data
);

    instruction_t  fetch_data;
    program_addr_t fetch_addr;
    reg_addr_t     rd_a_addr;
    reg_addr_t     rd_b_addr;
    data_t         rd_a_data;
    data_t         rd_b_data;
    logic          wr_en;
    reg_addr_t     wr_addr;
    data_t         wr_data;

    // Issue and writeback path between sequencer and ALU
    exec_if exec_bus ();

    // Host loads the program straight through the write strobe
    fcore_program_memory program_memory (
        .clock      (clock),
        .rst_n      (rst_n),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    // Operand reads come from the control unit, writes from the executor
    fcore_register_file register_file (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_a_addr (rd_a_addr),
        .rd_a_data (rd_a_data),
        .rd_b_addr (rd_b_addr),
        .rd_b_data (rd_b_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .host_addr (reg_rd_addr),
        .host_data (reg_rd_data)
    );

    fcore_control_unit control_unit (
        .clock      (clock),
        .rst_n      (rst_n),
        .run        (run),
        .done       (done),
        .busy       (busy),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .rd_a_addr  (rd_a_addr),
        .rd_a_data  (rd_a_data),
        .rd_b_addr  (rd_b_addr),
        .rd_b_data  (rd_b_data),
        .exec       (exec_bus.control)
    );

    fcore_executor executor (
        .clock   (clock),
        .rst_n   (rst_n),
        .exec    (exec_bus.executor),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

endmodule

//--- tb/fcore_properties.sv
`timescale 1ns/1ps

module fcore_properties (
    input logic clock,
    input logic rst_n,
    input logic done,
    input logic busy,
    input logic wr_en
);

    // done is a pulse that never lasts two cycles
    assert property (@(posedge clock) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // The core is back in idle in the cycle that done shows
    assert property (@(posedge clock) disable iff (!rst_n) done |-> !busy)
        else $error("done and busy were high together");

    // Writeback only happens inside a running program
    assert property (@(posedge clock) disable iff (!rst_n) !busy |-> !wr_en)
        else $error("register write strobe high while the core is idle");

endmodule

// wr_en is the executor's write strobe inside the top level
bind fcore fcore_properties i_properties (
    .clock (clock),
    .rst_n (rst_n),
    .done  (done),
    .busy  (busy),
    .wr_en (wr_en)
);

//--- tb/fcore_conditional_select_tb.sv
`timescale 1ns/1ps

module fcore_conditional_select_tb import fcore_pkg::*; ();

    localparam int unsigned SEED = 60;
    localparam int DIRECTED_ROWS = 10;
    localparam int RANDOM_ROWS = 12;
    // Generous cycle budget for loading, running and reading back one row
    localparam int ROW_CYCLES = 64;
    localparam int WATCHDOG_CYCLES = 2 * (DIRECTED_ROWS + RANDOM_ROWS) * ROW_CYCLES;
    // Seven instructions at three cycles each, minus the stop's write cycle
    localparam int DONE_LATENCY = 20;
    // Cycle after run at which a second run is driven while the core is busy
    localparam int STRAY_RUN_CYCLE = 6;

    // One test case: operands, compare opcode and the value csel must pick
    typedef struct packed {
        immediate_t a;
        immediate_t b;
        opcode_e    cmp;
        data_t      expected;
    } row_t;

    logic          clock;
    logic          rst_n;
    logic          run;
    logic          done;
    logic          busy;
    logic          prog_we;
    program_addr_t prog_addr;
    instruction_t  prog_data;
    reg_addr_t     reg_rd_addr;
    data_t         reg_rd_data;
    row_t          rows [$];
    int            errors;

    fcore i_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .run         (run),
        .done        (done),
        .busy        (busy),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .reg_rd_addr (reg_rd_addr),
        .reg_rd_data (reg_rd_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Every mismatch ends the run right here
    task automatic check_value(string name, data_t actual, data_t expected);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "first mismatch on %s", name);
        end
    endtask

    // Word layout is opcode, dest, src_a, src_b and a 16-bit immediate
    function automatic instruction_t encode(opcode_e op, reg_addr_t dest, reg_addr_t src_a,
                                            reg_addr_t src_b, immediate_t imm);
        return {op, dest, src_a, src_b, imm};
    endfunction

    // Reference rule for csel after a signed compare of the two operands
    function automatic data_t select_model(opcode_e cmp, data_t a, data_t b);
        logic holds;
        case (cmp)
            op_bgt:  holds = $signed(a) > $signed(b);
            op_ble:  holds = $signed(a) <= $signed(b);
            default: holds = (a == b);
        endcase
        return holds ? a : b;
    endfunction

    task automatic add_row(immediate_t a, immediate_t b, opcode_e cmp, data_t expected);
        row_t row;
        row.a = a;
        row.b = b;
        row.cmp = cmp;
        row.expected = expected;
        rows.push_back(row);
    endtask

    task automatic build_table();
        immediate_t a;
        immediate_t b;
        opcode_e    cmp;
        add_row(16'h0005, 16'h0003, op_bgt, 32'h0000_0005);
        add_row(16'h0003, 16'h0005, op_bgt, 32'h0000_0005);
        add_row(16'h0003, 16'h0005, op_ble, 32'h0000_0003);
        add_row(16'h0005, 16'h0003, op_ble, 32'h0000_0003);
        add_row(16'h0009, 16'h0009, op_ble, 32'h0000_0009);
        add_row(16'h0009, 16'h0009, op_bgt, 32'h0000_0009);
        add_row(16'h1234, 16'h1234, op_beq, 32'h0000_1234);
        add_row(16'hffff, 16'h8000, op_beq, 32'h0000_8000);
        // Zero extension keeps 0x8000 positive, so it wins against 1
        add_row(16'h8000, 16'h0001, op_bgt, 32'h0000_8000);
        add_row(16'h0000, 16'hffff, op_ble, 32'h0000_0000);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            a = immediate_t'($urandom);
            // Every fourth random row repeats a so that equal operands come up
            b = (i % 4 == 0) ? a : immediate_t'($urandom);
            case (i % 3)
                0:       cmp = op_bgt;
                1:       cmp = op_ble;
                default: cmp = op_beq;
            endcase
            add_row(a, b, cmp, select_model(cmp, data_t'(a), data_t'(b)));
        end
    endtask

    task automatic load_program(immediate_t a, immediate_t b, opcode_e cmp);
        instruction_t words [7];
        words[0] = encode(op_ldi, 4'd1, 4'd0, 4'd0, a);
        words[1] = encode(op_ldi, 4'd2, 4'd0, 4'd0, b);
        words[2] = encode(cmp, 4'd0, 4'd1, 4'd2, 16'h0000);
        words[3] = encode(op_csel, 4'd3, 4'd1, 4'd2, 16'h0000);
        words[4] = encode(op_sub, 4'd4, 4'd1, 4'd2, 16'h0000);
        words[5] = encode(op_add, 4'd5, 4'd3, 4'd4, 16'h0000);
        words[6] = encode(op_stop, 4'd0, 4'd0, 4'd0, 16'h0000);
        for (int i = 0; i < 7; i++) begin
            @(posedge clock);
            prog_we <= 1'b1;
            prog_addr <= program_addr_t'(i);
            prog_data <= words[i];
        end
        @(posedge clock);
        prog_we <= 1'b0;
    endtask

    // Host read port answers one cycle after the address
    task automatic read_register(reg_addr_t addr, output data_t value);
        @(posedge clock);
        reg_rd_addr <= addr;
        @(posedge clock);
        @(negedge clock);
        value = reg_rd_data;
    endtask

    task automatic run_program();
        int cycles;
        @(posedge clock);
        run <= 1'b1;
        // The core samples run at this edge, cycles count from here
        @(posedge clock);
        run <= 1'b0;
        @(negedge clock);
        cycles = 0;
        while (!done && cycles < 2 * DONE_LATENCY) begin
            check_value("busy", busy, 1);
            @(posedge clock);
            run <= (cycles == STRAY_RUN_CYCLE);
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            $display("done did not arrive within %0d cycles after run", cycles);
            $display("=== FAIL ===");
            $fatal(1, "missing done");
        end else begin
            check_value("done_latency", data_t'(cycles), data_t'(DONE_LATENCY));
            check_value("busy", busy, 0);
            // A single pulse, and the stray run must not start a second program
            repeat (4) begin
                @(negedge clock);
                check_value("done", done, 0);
                check_value("busy", busy, 0);
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout after %0d cycles, done never arrived", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        data_t value;
        data_t a32;
        data_t b32;
        void'($urandom(SEED));
        errors = 0;
        rst_n = 1'b0;
        run = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        reg_rd_addr = '0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_value("done", done, 0);
        check_value("busy", busy, 0);
        for (int r = 0; r < REG_COUNT; r++) begin
            read_register(reg_addr_t'(r), value);
            check_value("reg_rd_data", value, '0);
        end
        build_table();
        foreach (rows[i]) begin
            load_program(rows[i].a, rows[i].b, rows[i].cmp);
            run_program();
            a32 = data_t'(rows[i].a);
            b32 = data_t'(rows[i].b);
            read_register(4'd3, value);
            check_value("r3", value, rows[i].expected);
            read_register(4'd4, value);
            check_value("r4", value, a32 - b32);
            read_register(4'd5, value);
            check_value("r5", value, rows[i].expected + (a32 - b32));
        end
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sim.f
hw/fcore_pkg.sv
hw/exec_if.sv
hw/fcore_program_memory.sv
hw/fcore_register_file.sv
hw/fcore_control_unit.sv
hw/fcore_executor.sv
hw/fcore.sv
tb/fcore_properties.sv
tb/fcore_conditional_select_tb.sv

//--- Bender.yml
package:
  name: fcore

dependencies: {}

sources:
  - hw/fcore_pkg.sv
  - hw/exec_if.sv
  - hw/fcore_program_memory.sv
  - hw/fcore_register_file.sv
  - hw/fcore_control_unit.sv
  - hw/fcore_executor.sv
  - hw/fcore.sv
  - target: test
    files:
      - tb/fcore_properties.sv
      - tb/fcore_conditional_select_tb.sv
